/* hdl/axi_lite_pkg.sv */
// Register map and bus definitions for the AXI4-Lite control port.
// Imported by the register slave, the top level and the testbench.
package axi_lite_pkg;

	localparam int ADDR_W = 8;
	localparam int DATA_W = 32;

	typedef logic [ADDR_W-1:0]   axi_addr_t;
	typedef logic [DATA_W-1:0]   axi_data_t;
	typedef logic [DATA_W/8-1:0] axi_strb_t;
	typedef logic [1:0]          axi_resp_t;

	localparam axi_resp_t RESP_OKAY   = 2'b00;
	localparam axi_resp_t RESP_SLVERR = 2'b10;

	localparam axi_addr_t ADDR_CONTROL   = 8'h00;
	localparam axi_addr_t ADDR_ITEM_BASE = 8'h10;

	// control register bits
	localparam int CTRL_START_BIT = 0;
	localparam int CTRL_BUSY_BIT  = 0;
	localparam int CTRL_COUNT_LSB = 8;

	// item word layout, kind is the 2-bit register encoding
	localparam int ITEM_X_LSB    = 0;
	localparam int ITEM_X_MSB    = 8;
	localparam int ITEM_Y_LSB    = 9;
	localparam int ITEM_Y_MSB    = 16;
	localparam int ITEM_KIND_LSB = 17;
	localparam int ITEM_KIND_MSB = 18;

endpackage

/* hdl/render_pkg.sv */
// Screen geometry, sprite constants, palette and pixel types for the scene renderer.
// Every pipeline stage imports it.
package render_pkg;

	localparam int SCREEN_W    = 320;
	localparam int SCREEN_H    = 240;
	localparam int SPRITE_SIZE = 16;
	localparam int ITEM_COUNT  = 8;
	localparam int GROUND_Y    = 80;

	// diamond shape, a clipped square rotated by 45 degrees
	localparam int DIAMOND_SUM_MIN  = 7;
	localparam int DIAMOND_SUM_MAX  = 23;
	localparam int DIAMOND_SKEW_MAX = 8;

	typedef logic [8:0]  coord_x_t;
	typedef logic [7:0]  coord_y_t;
	typedef logic [11:0] color_t;
	typedef logic [3:0]  offset_t;
	typedef logic [2:0]  item_index_t;
	typedef logic [7:0]  frame_count_t;

	// the first four values match the 2-bit register encoding
	typedef enum logic [2:0] {
		kind_none       = 3'd0,
		kind_gold       = 3'd1,
		kind_stone      = 3'd2,
		kind_diamond    = 3'd3,
		kind_background = 3'd4
	} object_kind_t;

	localparam color_t COLOR_SKY         = 12'h6cf;
	localparam color_t COLOR_GROUND      = 12'h842;
	localparam color_t COLOR_GOLD        = 12'hfd0;
	localparam color_t COLOR_STONE       = 12'h888;
	localparam color_t COLOR_STONE_EDGE  = 12'h555;
	localparam color_t COLOR_DIAMOND     = 12'h0ff;
	localparam color_t COLOR_TRANSPARENT = 12'h000;

endpackage

/* hdl/item_table_regs.sv */
// AXI4-Lite slave with the control register and the eight-entry item table.
// The sequencer reads one table entry at a time through item_sel.
module item_table_regs
	import render_pkg::*;
	import axi_lite_pkg::*;
(
	input  logic         clk,
	input  logic         rst,
	input  axi_addr_t    s_axi_awaddr,
	input  logic         s_axi_awvalid,
	output logic         s_axi_awready,
	input  axi_data_t    s_axi_wdata,
	input  axi_strb_t    s_axi_wstrb,
	input  logic         s_axi_wvalid,
	output logic         s_axi_wready,
	output axi_resp_t    s_axi_bresp,
	output logic         s_axi_bvalid,
	input  logic         s_axi_bready,
	input  axi_addr_t    s_axi_araddr,
	input  logic         s_axi_arvalid,
	output logic         s_axi_arready,
	output axi_data_t    s_axi_rdata,
	output axi_resp_t    s_axi_rresp,
	output logic         s_axi_rvalid,
	input  logic         s_axi_rready,
	input  logic         busy,
	input  frame_count_t frame_count,
	output logic         start,
	input  item_index_t  item_sel,
	output coord_x_t     item_x,
	output coord_y_t     item_y,
	output object_kind_t item_kind
);

	coord_x_t   x_mem [ITEM_COUNT];
	coord_y_t   y_mem [ITEM_COUNT];
	logic [1:0] kind_mem [ITEM_COUNT];

	logic        wr_fire;
	logic        rd_fire;
	axi_data_t   wr_mask;
	axi_data_t   wr_word;
	item_index_t wr_index;

	function automatic logic is_item(input axi_addr_t addr);
		return addr >= ADDR_ITEM_BASE && addr < ADDR_ITEM_BASE + 4 * ITEM_COUNT &&
			addr[1:0] == 2'b00;
	endfunction

	function automatic item_index_t item_index(input axi_addr_t addr);
		axi_addr_t rel;
		rel = addr - ADDR_ITEM_BASE;
		return item_index_t'(rel >> 2);
	endfunction

	function automatic axi_data_t item_word(input item_index_t i);
		axi_data_t w;
		w = '0;
		w[ITEM_X_MSB:ITEM_X_LSB] = x_mem[i];
		w[ITEM_Y_MSB:ITEM_Y_LSB] = y_mem[i];
		w[ITEM_KIND_MSB:ITEM_KIND_LSB] = kind_mem[i];
		return w;
	endfunction

	// readies are only raised with both valids present, so one ready tells the handshake
	assign wr_fire = s_axi_awready && s_axi_awvalid && s_axi_wvalid;
	assign rd_fire = s_axi_arready && s_axi_arvalid;
	assign wr_index = item_index(s_axi_awaddr);

	always_comb begin
		for (int b = 0; b < DATA_W / 8; b++) begin
			wr_mask[8*b +: 8] = {8{s_axi_wstrb[b]}};
		end
		wr_word = (item_word(wr_index) & ~wr_mask) | (s_axi_wdata & wr_mask);
	end

	assign start = wr_fire && s_axi_awaddr == ADDR_CONTROL && s_axi_wstrb[0] &&
		s_axi_wdata[CTRL_START_BIT] && !busy;

	always_ff @(posedge clk) begin
		if (rst) begin
			s_axi_awready <= 1'b0;
			s_axi_wready <= 1'b0;
			s_axi_bvalid <= 1'b0;
		end else begin
			s_axi_awready <= s_axi_awvalid && s_axi_wvalid && !s_axi_bvalid && !s_axi_awready;
			s_axi_wready <= s_axi_awvalid && s_axi_wvalid && !s_axi_bvalid && !s_axi_awready;
			if (wr_fire) begin
				s_axi_bvalid <= 1'b1;
			end else if (s_axi_bready) begin
				s_axi_bvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_fire) begin
			if (s_axi_awaddr == ADDR_CONTROL || is_item(s_axi_awaddr)) begin
				s_axi_bresp <= RESP_OKAY;
			end else begin
				s_axi_bresp <= RESP_SLVERR;
			end
		end
	end

	// kinds are reset so an unwritten table renders as empty
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < ITEM_COUNT; i++) begin
				kind_mem[i] <= 2'b00;
			end
		end else if (wr_fire && is_item(s_axi_awaddr)) begin
			kind_mem[wr_index] <= wr_word[ITEM_KIND_MSB:ITEM_KIND_LSB];
		end
	end

	always_ff @(posedge clk) begin
		if (wr_fire && is_item(s_axi_awaddr)) begin
			x_mem[wr_index] <= wr_word[ITEM_X_MSB:ITEM_X_LSB];
			y_mem[wr_index] <= wr_word[ITEM_Y_MSB:ITEM_Y_LSB];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			s_axi_arready <= 1'b0;
			s_axi_rvalid <= 1'b0;
		end else begin
			s_axi_arready <= s_axi_arvalid && !s_axi_rvalid && !s_axi_arready;
			if (rd_fire) begin
				s_axi_rvalid <= 1'b1;
			end else if (s_axi_rready) begin
				s_axi_rvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rd_fire) begin
			s_axi_rdata <= '0;
			s_axi_rresp <= RESP_OKAY;
			if (s_axi_araddr == ADDR_CONTROL) begin
				s_axi_rdata[CTRL_BUSY_BIT] <= busy;
				s_axi_rdata[CTRL_COUNT_LSB +: 8] <= frame_count;
			end else if (is_item(s_axi_araddr)) begin
				s_axi_rdata <= item_word(item_index(s_axi_araddr));
			end else begin
				s_axi_rresp <= RESP_SLVERR;
			end
		end
	end

	assign item_x = x_mem[item_sel];
	assign item_y = y_mem[item_sel];
	assign item_kind = object_kind_t'({1'b0, kind_mem[item_sel]});

endmodule

/* hdl/scene_sequencer.sv */
// Frame FSM. Issues the background request, then one request per present item,
// and closes the frame when the shader reports the last pixel.
module scene_sequencer
	import render_pkg::*;
(
	input  logic         clk,
	input  logic         rst,
	input  logic         start,
	output item_index_t  item_sel,
	input  coord_x_t     item_x,
	input  coord_y_t     item_y,
	input  object_kind_t item_kind,
	output logic         req_valid,
	input  logic         req_ready,
	output object_kind_t req_kind,
	output coord_x_t     req_x,
	output coord_y_t     req_y,
	output logic         req_last,
	input  logic         frame_end,
	output logic         busy,
	output logic         frame_done,
	output frame_count_t frame_count
);

	typedef enum logic [1:0] {
		st_idle,
		st_background,
		st_items,
		st_wait_end
	} state_t;

	state_t state;
	logic   walk_done;
	logic   req_free;

	// one request is held back until we know whether another one follows it
	object_kind_t cand_kind;
	coord_x_t     cand_x;
	coord_y_t     cand_y;

	assign req_free = !req_valid || req_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
			item_sel <= '0;
			walk_done <= 1'b0;
			req_valid <= 1'b0;
			busy <= 1'b0;
			frame_done <= 1'b0;
			frame_count <= '0;
		end else begin
			frame_done <= 1'b0;
			if (req_valid && req_ready) begin
				req_valid <= 1'b0;
			end
			case (state)
				st_idle: begin
					if (start) begin
						busy <= 1'b1;
						state <= st_background;
					end
				end
				st_background: begin
					item_sel <= '0;
					walk_done <= 1'b0;
					state <= st_items;
				end
				st_items: begin
					if (!walk_done) begin
						if (item_kind == kind_none || req_free) begin
							if (item_sel == item_index_t'(ITEM_COUNT - 1)) begin
								walk_done <= 1'b1;
							end else begin
								item_sel <= item_sel + 1'b1;
							end
						end
						if (item_kind != kind_none && req_free) begin
							req_valid <= 1'b1;
						end
					end else if (req_free) begin
						req_valid <= 1'b1;
						state <= st_wait_end;
					end
				end
				st_wait_end: begin
					if (frame_end) begin
						busy <= 1'b0;
						frame_done <= 1'b1;
						frame_count <= frame_count + 1'b1;
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_background) begin
			cand_kind <= kind_background;
			cand_x <= '0;
			cand_y <= '0;
		end else if (state == st_items && req_free) begin
			if (!walk_done && item_kind != kind_none) begin
				req_kind <= cand_kind;
				req_x <= cand_x;
				req_y <= cand_y;
				req_last <= 1'b0;
				cand_kind <= item_kind;
				cand_x <= item_x;
				cand_y <= item_y;
			end else if (walk_done) begin
				req_kind <= cand_kind;
				req_x <= cand_x;
				req_y <= cand_y;
				req_last <= 1'b1;
			end
		end
	end

endmodule

/* hdl/sprite_scanner.sv */
// Walks the raster of one draw request at a time and emits on-screen positions
// with their offsets inside the sprite.
module sprite_scanner
	import render_pkg::*;
(
	input  logic         clk,
	input  logic         rst,
	input  logic         req_valid,
	output logic         req_ready,
	input  object_kind_t req_kind,
	input  coord_x_t     req_x,
	input  coord_y_t     req_y,
	input  logic         req_last,
	output logic         scan_valid,
	input  logic         scan_ready,
	output coord_x_t     scan_x,
	output coord_y_t     scan_y,
	output offset_t      scan_ox,
	output offset_t      scan_oy,
	output object_kind_t scan_kind,
	output logic         scan_last
);

	logic         active;
	object_kind_t cur_kind;
	coord_x_t     cur_x;
	coord_y_t     cur_y;
	logic         cur_last;
	coord_x_t     cnt_x;
	coord_y_t     cnt_y;

	coord_x_t   end_x;
	coord_y_t   end_y;
	logic [9:0] pos_x;
	logic [8:0] pos_y;
	logic       on_screen;
	logic       at_end;
	logic       need_out;
	logic       step;
	logic       emit;

	always_comb begin
		end_x = (cur_kind == kind_background) ? coord_x_t'(SCREEN_W - 1) :
			coord_x_t'(SPRITE_SIZE - 1);
		end_y = (cur_kind == kind_background) ? coord_y_t'(SCREEN_H - 1) :
			coord_y_t'(SPRITE_SIZE - 1);
		// one extra bit so sprites hanging past the edge do not wrap
		pos_x = {1'b0, cur_x} + {1'b0, cnt_x};
		pos_y = {1'b0, cur_y} + {1'b0, cnt_y};
		on_screen = pos_x < 10'(SCREEN_W) && pos_y < 9'(SCREEN_H);
		at_end = cnt_x == end_x && cnt_y == end_y;
		// the final position of the frame always goes out so the end is seen
		need_out = on_screen || (at_end && cur_last);
		step = active && (!need_out || !scan_valid || scan_ready);
		emit = step && need_out;
	end

	assign req_ready = !active;

	always_ff @(posedge clk) begin
		if (rst) begin
			active <= 1'b0;
			scan_valid <= 1'b0;
		end else begin
			if (req_valid && req_ready) begin
				active <= 1'b1;
			end else if (step && at_end) begin
				active <= 1'b0;
			end
			if (emit) begin
				scan_valid <= 1'b1;
			end else if (scan_ready) begin
				scan_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (req_valid && req_ready) begin
			cur_kind <= req_kind;
			cur_x <= req_x;
			cur_y <= req_y;
			cur_last <= req_last;
			cnt_x <= '0;
			cnt_y <= '0;
		end else if (step && !at_end) begin
			if (cnt_x == end_x) begin
				cnt_x <= '0;
				cnt_y <= cnt_y + 1'b1;
			end else begin
				cnt_x <= cnt_x + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (emit) begin
			scan_x <= pos_x[8:0];
			scan_y <= pos_y[7:0];
			scan_ox <= cnt_x[3:0];
			scan_oy <= cnt_y[3:0];
			scan_kind <= on_screen ? cur_kind : kind_none;
			scan_last <= at_end && cur_last;
		end
	end

endmodule

/* hdl/sprite_shader.sv */
// Colors each scanned position by kind and offset, drops transparent pixels
// and drives the frame-buffer write stream.
module sprite_shader
	import render_pkg::*;
(
	input  logic         clk,
	input  logic         rst,
	input  logic         scan_valid,
	output logic         scan_ready,
	input  coord_x_t     scan_x,
	input  coord_y_t     scan_y,
	input  offset_t      scan_ox,
	input  offset_t      scan_oy,
	input  object_kind_t scan_kind,
	input  logic         scan_last,
	output logic         pixel_valid,
	input  logic         pixel_ready,
	output coord_x_t     pixel_x,
	output coord_y_t     pixel_y,
	output color_t       pixel_color,
	output logic         frame_end
);

	localparam offset_t EDGE = offset_t'(SPRITE_SIZE - 1);

	color_t     color;
	logic       opaque;
	logic       take;
	logic [4:0] sum;
	offset_t    skew;
	logic       out_last;

	always_comb begin
		sum = {1'b0, scan_ox} + {1'b0, scan_oy};
		skew = (scan_ox >= scan_oy) ? scan_ox - scan_oy : scan_oy - scan_ox;
		case (scan_kind)
			kind_background: color = (scan_y < coord_y_t'(GROUND_Y)) ? COLOR_SKY : COLOR_GROUND;
			kind_gold: begin
				if ((scan_ox == 0 || scan_ox == EDGE) && (scan_oy == 0 || scan_oy == EDGE))
					color = COLOR_TRANSPARENT;
				else
					color = COLOR_GOLD;
			end
			kind_stone: color = (scan_oy == EDGE) ? COLOR_STONE_EDGE : COLOR_STONE;
			kind_diamond: begin
				if (sum >= 5'(DIAMOND_SUM_MIN) && sum <= 5'(DIAMOND_SUM_MAX) &&
					skew <= offset_t'(DIAMOND_SKEW_MAX))
					color = COLOR_DIAMOND;
				else
					color = COLOR_TRANSPARENT;
			end
			default: color = COLOR_TRANSPARENT;
		endcase
		opaque = color != COLOR_TRANSPARENT;
	end

	assign scan_ready = !pixel_valid || pixel_ready;
	assign take = scan_valid && scan_ready;

	// last pixel leaves either by transfer or by being dropped here
	assign frame_end = (pixel_valid && pixel_ready && out_last) ||
		(take && scan_last && !opaque);

	always_ff @(posedge clk) begin
		if (rst) begin
			pixel_valid <= 1'b0;
		end else if (take && opaque) begin
			pixel_valid <= 1'b1;
		end else if (pixel_ready) begin
			pixel_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (take && opaque) begin
			pixel_x <= scan_x;
			pixel_y <= scan_y;
			pixel_color <= color;
			out_last <= scan_last;
		end
	end

endmodule

/* hdl/scene_renderer.sv */
// Scene renderer top level. The register slave feeds the sequencer, scanner
// and shader, which stream pixel writes to an external frame buffer.
module scene_renderer
	import render_pkg::*;
	import axi_lite_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  axi_addr_t s_axi_awaddr,
	input  logic      s_axi_awvalid,
	output logic      s_axi_awready,
	input  axi_data_t s_axi_wdata,
	input  axi_strb_t s_axi_wstrb,
	input  logic      s_axi_wvalid,
	output logic      s_axi_wready,
	output axi_resp_t s_axi_bresp,
	output logic      s_axi_bvalid,
	input  logic      s_axi_bready,
	input  axi_addr_t s_axi_araddr,
	input  logic      s_axi_arvalid,
	output logic      s_axi_arready,
	output axi_data_t s_axi_rdata,
	output axi_resp_t s_axi_rresp,
	output logic      s_axi_rvalid,
	input  logic      s_axi_rready,
	output coord_x_t  pixel_x,
	output coord_y_t  pixel_y,
	output color_t    pixel_color,
	output logic      pixel_valid,
	input  logic      pixel_ready,
	output logic      frame_done,
	output logic      busy
);

	logic         start;
	frame_count_t frame_count;
	item_index_t  item_sel;
	coord_x_t     item_x;
	coord_y_t     item_y;
	object_kind_t item_kind;

	logic         req_valid;
	logic         req_ready;
	object_kind_t req_kind;
	coord_x_t     req_x;
	coord_y_t     req_y;
	logic         req_last;

	logic         scan_valid;
	logic         scan_ready;
	coord_x_t     scan_x;
	coord_y_t     scan_y;
	offset_t      scan_ox;
	offset_t      scan_oy;
	object_kind_t scan_kind;
	logic         scan_last;
	logic         frame_end;

	item_table_regs item_table_regs_i (
		.clk(clk),
		.rst(rst),
		.s_axi_awaddr(s_axi_awaddr),
		.s_axi_awvalid(s_axi_awvalid),
		.s_axi_awready(s_axi_awready),
		.s_axi_wdata(s_axi_wdata),
		.s_axi_wstrb(s_axi_wstrb),
		.s_axi_wvalid(s_axi_wvalid),
		.s_axi_wready(s_axi_wready),
		.s_axi_bresp(s_axi_bresp),
		.s_axi_bvalid(s_axi_bvalid),
		.s_axi_bready(s_axi_bready),
		.s_axi_araddr(s_axi_araddr),
		.s_axi_arvalid(s_axi_arvalid),
		.s_axi_arready(s_axi_arready),
		.s_axi_rdata(s_axi_rdata),
		.s_axi_rresp(s_axi_rresp),
		.s_axi_rvalid(s_axi_rvalid),
		.s_axi_rready(s_axi_rready),
		.busy(busy),
		.frame_count(frame_count),
		.start(start),
		.item_sel(item_sel),
		.item_x(item_x),
		.item_y(item_y),
		.item_kind(item_kind)
	);

	scene_sequencer scene_sequencer_i (
		.clk(clk),
		.rst(rst),
		.start(start),
		.item_sel(item_sel),
		.item_x(item_x),
		.item_y(item_y),
		.item_kind(item_kind),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.req_kind(req_kind),
		.req_x(req_x),
		.req_y(req_y),
		.req_last(req_last),
		.frame_end(frame_end),
		.busy(busy),
		.frame_done(frame_done),
		.frame_count(frame_count)
	);

	sprite_scanner sprite_scanner_i (
		.clk(clk),
		.rst(rst),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.req_kind(req_kind),
		.req_x(req_x),
		.req_y(req_y),
		.req_last(req_last),
		.scan_valid(scan_valid),
		.scan_ready(scan_ready),
		.scan_x(scan_x),
		.scan_y(scan_y),
		.scan_ox(scan_ox),
		.scan_oy(scan_oy),
		.scan_kind(scan_kind),
		.scan_last(scan_last)
	);

	sprite_shader sprite_shader_i (
		.clk(clk),
		.rst(rst),
		.scan_valid(scan_valid),
		.scan_ready(scan_ready),
		.scan_x(scan_x),
		.scan_y(scan_y),
		.scan_ox(scan_ox),
		.scan_oy(scan_oy),
		.scan_kind(scan_kind),
		.scan_last(scan_last),
		.pixel_valid(pixel_valid),
		.pixel_ready(pixel_ready),
		.pixel_x(pixel_x),
		.pixel_y(pixel_y),
		.pixel_color(pixel_color),
		.frame_end(frame_end)
	);

endmodule

/* testbench/scene_renderer_properties.sv */
// Handshake assertions on the scene renderer top level, attached with bind.
module scene_renderer_properties
	import render_pkg::*;
	import axi_lite_pkg::*;
(
	input logic      clk,
	input logic      rst,
	input logic      pixel_valid,
	input logic      pixel_ready,
	input coord_x_t  pixel_x,
	input coord_y_t  pixel_y,
	input color_t    pixel_color,
	input logic      frame_done,
	input logic      busy,
	input logic      s_axi_bvalid,
	input logic      s_axi_bready,
	input axi_resp_t s_axi_bresp,
	input logic      s_axi_rvalid,
	input logic      s_axi_rready,
	input axi_data_t s_axi_rdata,
	input axi_resp_t s_axi_rresp
);

	int failures = 0;

	pixel_stable: assert property (@(posedge clk) disable iff (rst)
		pixel_valid && !pixel_ready |=> pixel_valid && $stable(pixel_x) &&
			$stable(pixel_y) && $stable(pixel_color))
		else begin
			$error("pixel write changed while stalled");
			failures++;
		end

	// busy drops in the same cycle frame_done pulses
	done_in_frame: assert property (@(posedge clk) disable iff (rst)
		frame_done |-> $past(busy))
		else begin
			$error("frame_done without a running frame");
			failures++;
		end

	b_hold: assert property (@(posedge clk) disable iff (rst)
		s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid && $stable(s_axi_bresp))
		else begin
			$error("write response dropped before it was accepted");
			failures++;
		end

	r_hold: assert property (@(posedge clk) disable iff (rst)
		s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata) &&
			$stable(s_axi_rresp))
		else begin
			$error("read response dropped before it was accepted");
			failures++;
		end

endmodule

bind scene_renderer scene_renderer_properties scene_renderer_properties_i (
	.clk(clk),
	.rst(rst),
	.pixel_valid(pixel_valid),
	.pixel_ready(pixel_ready),
	.pixel_x(pixel_x),
	.pixel_y(pixel_y),
	.pixel_color(pixel_color),
	.frame_done(frame_done),
	.busy(busy),
	.s_axi_bvalid(s_axi_bvalid),
	.s_axi_bready(s_axi_bready),
	.s_axi_bresp(s_axi_bresp),
	.s_axi_rvalid(s_axi_rvalid),
	.s_axi_rready(s_axi_rready),
	.s_axi_rdata(s_axi_rdata),
	.s_axi_rresp(s_axi_rresp)
);

/* testbench/scene_renderer_tb.sv */
// Directed testbench for the scene renderer.
// A reference model builds each frame's expected pixel stream from the color and clipping rules.
module scene_renderer_tb
	import render_pkg::*;
	import axi_lite_pkg::*;
();

	localparam int AXI_TIMEOUT   = 100;
	localparam int FRAME_TIMEOUT = 400000;
	localparam int IDLE_CHECK    = 64;

	// register encoding of the item kind
	localparam int REG_NONE    = 0;
	localparam int REG_GOLD    = 1;
	localparam int REG_STONE   = 2;
	localparam int REG_DIAMOND = 3;

	logic      clk;
	logic      rst;
	axi_addr_t s_axi_awaddr;
	logic      s_axi_awvalid;
	logic      s_axi_awready;
	axi_data_t s_axi_wdata;
	axi_strb_t s_axi_wstrb;
	logic      s_axi_wvalid;
	logic      s_axi_wready;
	axi_resp_t s_axi_bresp;
	logic      s_axi_bvalid;
	logic      s_axi_bready;
	axi_addr_t s_axi_araddr;
	logic      s_axi_arvalid;
	logic      s_axi_arready;
	axi_data_t s_axi_rdata;
	axi_resp_t s_axi_rresp;
	logic      s_axi_rvalid;
	logic      s_axi_rready;
	coord_x_t  pixel_x;
	coord_y_t  pixel_y;
	color_t    pixel_color;
	logic      pixel_valid;
	logic      pixel_ready;
	logic      frame_done;
	logic      busy;

	// host-side copy of the item table
	int tb_x [ITEM_COUNT];
	int tb_y [ITEM_COUNT];
	int tb_kind [ITEM_COUNT];

	logic [28:0] expected_q [$];
	int          frames_expected;
	string       test_name;

	scene_renderer scene_renderer_i (
		.clk(clk),
		.rst(rst),
		.s_axi_awaddr(s_axi_awaddr),
		.s_axi_awvalid(s_axi_awvalid),
		.s_axi_awready(s_axi_awready),
		.s_axi_wdata(s_axi_wdata),
		.s_axi_wstrb(s_axi_wstrb),
		.s_axi_wvalid(s_axi_wvalid),
		.s_axi_wready(s_axi_wready),
		.s_axi_bresp(s_axi_bresp),
		.s_axi_bvalid(s_axi_bvalid),
		.s_axi_bready(s_axi_bready),
		.s_axi_araddr(s_axi_araddr),
		.s_axi_arvalid(s_axi_arvalid),
		.s_axi_arready(s_axi_arready),
		.s_axi_rdata(s_axi_rdata),
		.s_axi_rresp(s_axi_rresp),
		.s_axi_rvalid(s_axi_rvalid),
		.s_axi_rready(s_axi_rready),
		.pixel_x(pixel_x),
		.pixel_y(pixel_y),
		.pixel_color(pixel_color),
		.pixel_valid(pixel_valid),
		.pixel_ready(pixel_ready),
		.frame_done(frame_done),
		.busy(busy)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped on first error");
	endtask

	always @(negedge clk) begin
		assert (scene_renderer_i.scene_renderer_properties_i.failures == 0) else
			stop_on_error("a handshake assertion on the top level failed");
	end

	task automatic axi_write(input axi_addr_t addr, input axi_data_t data, output axi_resp_t resp);
		int waited;
		@(negedge clk);
		s_axi_awaddr = addr;
		s_axi_wdata = data;
		s_axi_wstrb = '1;
		s_axi_awvalid = 1'b1;
		s_axi_wvalid = 1'b1;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
			assert (waited <= AXI_TIMEOUT) else
				stop_on_error($sformatf("%s: write address was never accepted", test_name));
		end while (!s_axi_awready);
		assert (s_axi_wready) else
			stop_on_error($sformatf("%s: write data was not accepted with its address",
				test_name));
		@(negedge clk);
		s_axi_awvalid = 1'b0;
		s_axi_wvalid = 1'b0;
		waited = 0;
		while (!s_axi_bvalid) begin
			@(negedge clk);
			waited++;
			assert (waited <= AXI_TIMEOUT) else
				stop_on_error($sformatf("%s: no write response arrived", test_name));
		end
		resp = s_axi_bresp;
		s_axi_bready = 1'b1;
		@(negedge clk);
		s_axi_bready = 1'b0;
	endtask

	task automatic axi_read(input axi_addr_t addr, output axi_data_t data, output axi_resp_t resp);
		int waited;
		@(negedge clk);
		s_axi_araddr = addr;
		s_axi_arvalid = 1'b1;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
			assert (waited <= AXI_TIMEOUT) else
				stop_on_error($sformatf("%s: read address was never accepted", test_name));
		end while (!s_axi_arready);
		@(negedge clk);
		s_axi_arvalid = 1'b0;
		waited = 0;
		while (!s_axi_rvalid) begin
			@(negedge clk);
			waited++;
			assert (waited <= AXI_TIMEOUT) else
				stop_on_error($sformatf("%s: no read data arrived", test_name));
		end
		data = s_axi_rdata;
		resp = s_axi_rresp;
		s_axi_rready = 1'b1;
		@(negedge clk);
		s_axi_rready = 1'b0;
	endtask

	task automatic expect_write(input axi_addr_t addr, input axi_data_t data,
		input axi_resp_t exp_resp);
		axi_resp_t resp;
		axi_write(addr, data, resp);
		assert (resp == exp_resp) else stop_on_error($sformatf(
			"MISMATCH %s write resp at %h expected %0d actual %0d",
			test_name, addr, exp_resp, resp));
	endtask

	task automatic expect_read(input axi_addr_t addr, input axi_data_t exp_data,
		input axi_resp_t exp_resp);
		axi_data_t data;
		axi_resp_t resp;
		axi_read(addr, data, resp);
		assert (resp == exp_resp) else stop_on_error($sformatf(
			"MISMATCH %s read resp at %h expected %0d actual %0d",
			test_name, addr, exp_resp, resp));
		assert (data == exp_data) else stop_on_error($sformatf(
			"MISMATCH %s read data at %h expected %h actual %h",
			test_name, addr, exp_data, data));
	endtask

	function automatic axi_data_t item_word(input int x, input int y, input int kind);
		axi_data_t w;
		w = '0;
		w[ITEM_X_MSB:ITEM_X_LSB] = coord_x_t'(x);
		w[ITEM_Y_MSB:ITEM_Y_LSB] = coord_y_t'(y);
		w[ITEM_KIND_MSB:ITEM_KIND_LSB] = 2'(kind);
		return w;
	endfunction

	task automatic set_item(input int i, input int x, input int y, input int kind);
		expect_write(ADDR_ITEM_BASE + axi_addr_t'(4 * i), item_word(x, y, kind), RESP_OKAY);
		tb_x[i] = x;
		tb_y[i] = y;
		tb_kind[i] = kind;
	endtask

	task automatic clear_items();
		for (int i = 0; i < ITEM_COUNT; i++) begin
			set_item(i, 0, 0, REG_NONE);
		end
	endtask

	function automatic color_t model_color(input int kind, input int ox, input int oy);
		int skew;
		int sum;
		color_t c;
		skew = (ox > oy) ? ox - oy : oy - ox;
		sum = ox + oy;
		c = COLOR_TRANSPARENT;
		if (kind == REG_GOLD) begin
			if (!((ox == 0 || ox == 15) && (oy == 0 || oy == 15)))
				c = COLOR_GOLD;
		end else if (kind == REG_STONE) begin
			c = (oy == 15) ? COLOR_STONE_EDGE : COLOR_STONE;
		end else if (kind == REG_DIAMOND) begin
			if (sum >= 7 && sum <= 23 && skew <= 8)
				c = COLOR_DIAMOND;
		end
		return c;
	endfunction

	task automatic build_expected();
		int px;
		int py;
		color_t c;
		expected_q.delete();
		for (int y = 0; y < SCREEN_H; y++) begin
			for (int x = 0; x < SCREEN_W; x++) begin
				c = (y < GROUND_Y) ? COLOR_SKY : COLOR_GROUND;
				expected_q.push_back({coord_x_t'(x), coord_y_t'(y), c});
			end
		end
		for (int i = 0; i < ITEM_COUNT; i++) begin
			if (tb_kind[i] != REG_NONE) begin
				for (int oy = 0; oy < SPRITE_SIZE; oy++) begin
					for (int ox = 0; ox < SPRITE_SIZE; ox++) begin
						px = tb_x[i] + ox;
						py = tb_y[i] + oy;
						c = model_color(tb_kind[i], ox, oy);
						if (px < SCREEN_W && py < SCREEN_H && c != COLOR_TRANSPARENT)
							expected_q.push_back({coord_x_t'(px), coord_y_t'(py), c});
					end
				end
			end
		end
	endtask

	// runs one frame and compares every pixel write with the model, optionally
	// with random back-pressure or an extra start write in the middle
	task automatic check_frame(input bit stall, input bit restart);
		int idx;
		int cycles;
		bit finished;
		logic [28:0] got;
		build_expected();
		@(negedge clk);
		pixel_ready = 1'b0;
		expect_write(ADDR_CONTROL, 32'h1, RESP_OKAY);
		frames_expected++;
		idx = 0;
		cycles = 0;
		finished = 1'b0;
		fork
			while (!finished) begin
				@(negedge clk);
				cycles++;
				assert (cycles <= FRAME_TIMEOUT) else
					stop_on_error($sformatf("%s: frame_done never arrived", test_name));
				pixel_ready = stall ? (($urandom % 3) != 0) : 1'b1;
				if (pixel_valid && pixel_ready) begin
					got = {pixel_x, pixel_y, pixel_color};
					assert (idx < expected_q.size()) else stop_on_error($sformatf(
						"%s: more pixels than expected, extra at x=%0d y=%0d",
						test_name, pixel_x, pixel_y));
					assert (got == expected_q[idx]) else stop_on_error($sformatf(
						"MISMATCH %s pixel %0d expected x=%0d y=%0d color=%h actual x=%0d y=%0d color=%h",
						test_name, idx, expected_q[idx][28:20], expected_q[idx][19:12],
						expected_q[idx][11:0], pixel_x, pixel_y, pixel_color));
					idx++;
				end
				if (frame_done) begin
					finished = 1'b1;
					assert (!busy) else
						stop_on_error($sformatf("%s: busy still high with frame_done", test_name));
				end else begin
					assert (busy) else
						stop_on_error($sformatf("%s: busy low before frame_done", test_name));
				end
			end
			if (restart) begin
				repeat (200) @(negedge clk);
				assert (busy) else
					stop_on_error($sformatf("%s: frame ended before the second start", test_name));
				expect_write(ADDR_CONTROL, 32'h1, RESP_OKAY);
			end
		join
		assert (idx == expected_q.size()) else stop_on_error($sformatf(
			"MISMATCH %s pixel count expected %0d actual %0d", test_name, expected_q.size(), idx));
		pixel_ready = 1'b1;
		for (int i = 0; i < IDLE_CHECK; i++) begin
			@(negedge clk);
			assert (!frame_done && !busy && !pixel_valid) else
				stop_on_error($sformatf("%s: activity after the frame ended", test_name));
		end
		expect_read(ADDR_CONTROL, axi_data_t'(frames_expected) << CTRL_COUNT_LSB, RESP_OKAY);
	endtask

	task automatic access_registers();
		test_name = "register_access";
		expect_read(ADDR_CONTROL, 32'h0, RESP_OKAY);
		expect_write(ADDR_ITEM_BASE + 8'h08, 32'hffff_ffff, RESP_OKAY);
		expect_read(ADDR_ITEM_BASE + 8'h08, 32'h0007_ffff, RESP_OKAY);
		expect_write(ADDR_ITEM_BASE + 8'h1c, 32'hfff8_0000 | item_word(123, 45, REG_STONE),
			RESP_OKAY);
		expect_read(ADDR_ITEM_BASE + 8'h1c, item_word(123, 45, REG_STONE), RESP_OKAY);
		expect_write(8'h40, 32'hdead_beef, RESP_SLVERR);
		expect_read(8'h40, 32'h0, RESP_SLVERR);
		expect_read(8'h04, 32'h0, RESP_SLVERR);
		clear_items();
	endtask

	task automatic draw_empty_table();
		test_name = "empty_table";
		clear_items();
		check_frame(1'b0, 1'b0);
	endtask

	task automatic show_each_kind();
		test_name = "each_kind";
		clear_items();
		set_item(0, 20, 30, REG_GOLD);
		set_item(1, 60, 30, REG_NONE);
		set_item(2, 100, 90, REG_STONE);
		set_item(3, 200, 150, REG_DIAMOND);
		check_frame(1'b0, 1'b0);
	endtask

	task automatic clip_screen_edges();
		test_name = "screen_edges";
		clear_items();
		set_item(0, 312, 40, REG_GOLD);
		set_item(1, 50, 232, REG_STONE);
		set_item(2, 312, 232, REG_DIAMOND);
		// last item lies fully off-screen
		set_item(3, 400, 100, REG_STONE);
		check_frame(1'b0, 1'b0);
	endtask

	task automatic stall_pixel_stream();
		test_name = "random_stalls";
		clear_items();
		set_item(0, 0, 0, REG_GOLD);
		set_item(1, 304, 224, REG_DIAMOND);
		set_item(2, 150, 72, REG_STONE);
		set_item(4, 310, 235, REG_GOLD);
		set_item(6, 60, 60, REG_STONE);
		check_frame(1'b1, 1'b0);
	endtask

	task automatic restart_while_busy();
		test_name = "busy_start";
		clear_items();
		set_item(5, 140, 110, REG_DIAMOND);
		check_frame(1'b0, 1'b1);
	endtask

	initial begin
		rst = 1'b1;
		s_axi_awaddr = '0;
		s_axi_awvalid = 1'b0;
		s_axi_wdata = '0;
		s_axi_wstrb = '0;
		s_axi_wvalid = 1'b0;
		s_axi_bready = 1'b0;
		s_axi_araddr = '0;
		s_axi_arvalid = 1'b0;
		s_axi_rready = 1'b0;
		pixel_ready = 1'b0;
		frames_expected = 0;
		test_name = "reset";
		void'($urandom(32'hfd4a_3c33));
		repeat (8) @(negedge clk);
		rst = 1'b0;
		access_registers();
		draw_empty_table();
		show_each_kind();
		clip_screen_edges();
		stall_pixel_stream();
		restart_while_busy();
		if (scene_renderer_i.scene_renderer_properties_i.failures == 0) begin
			$display("=== PASS ===");
			$finish;
		end else begin
			stop_on_error("a handshake assertion on the top level failed");
		end
	end

endmodule

/* tb.f */
hdl/axi_lite_pkg.sv
hdl/render_pkg.sv
hdl/item_table_regs.sv
hdl/scene_sequencer.sv
hdl/sprite_scanner.sv
hdl/sprite_shader.sv
hdl/scene_renderer.sv
testbench/scene_renderer_properties.sv
testbench/scene_renderer_tb.sv
